// ==== files.f ====
design/loader_pkg.sv
design/prg_injector.sv
design/crt_parser.sv
design/mem_write_queue.sv
design/c64_loader_top.sv
verif/tb_c64_loader_assert.sv
verif/tb_c64_loader.sv

// ==== Bender.yml ====
package:
  name: c64_loader

sources:
  # Package first, then the RTL from the leaves up
  - design/loader_pkg.sv
  - design/prg_injector.sv
  - design/crt_parser.sv
  - design/mem_write_queue.sv
  - design/c64_loader_top.sv
  # Testbench with its bound checker
  - target: test
    files:
      - verif/tb_c64_loader_assert.sv
      - verif/tb_c64_loader.sv

// ==== verif/tb_c64_loader.sv ====
//========================================
// Testbench for the loader top level
// LCG stimulus with PRG and CRT files
// Reference model of writes and bank records
// Compare tasks, watchdog and result line
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_c64_loader
	import loader_pkg::*;
();

	localparam int WQ_DEPTH = 4;
	localparam int ROUNDS   = 2;

	logic      clk_sys;
	logic      reset_n;
	logic      dl_valid_i;
	dl_index_t dl_index_i;
	mem_addr_t dl_addr_i;
	byte_t     dl_data_i;
	logic      dl_active_i;
	logic      mem_ready_i;
	logic      dl_ready_o;
	logic      mem_valid_o;
	mem_addr_t mem_addr_o;
	byte_t     mem_data_o;
	logic      busy_o;
	logic      bank_valid_o;
	byte_t     bank_type_o;
	crt_word_t bank_num_o;
	c64_addr_t bank_laddr_o;
	crt_word_t bank_size_o;
	mem_addr_t bank_raddr_o;
	crt_word_t cart_id_o;
	byte_t     cart_exrom_o;
	byte_t     cart_game_o;
	logic      cart_attached_o;

	// Stimulus, one flat byte stream cut into files
	byte_t     stim_q [$];
	int        file_len [$];
	dl_index_t file_idx [$];
	// Stream positions of the last CHIP header bytes
	int        bank_end [$];
	// Expected results in arrival order
	mem_addr_t exp_addr [$];
	byte_t     exp_data [$];
	byte_t     exp_type [$];
	crt_word_t exp_num [$];
	c64_addr_t exp_laddr [$];
	crt_word_t exp_size [$];
	mem_addr_t exp_raddr [$];
	crt_word_t exp_id [$];
	byte_t     exp_exrom [$];
	byte_t     exp_game [$];

	int          write_errs = 0;
	int          bank_errs = 0;
	int          cart_errs = 0;
	int          flag_errs = 0;
	int          stim_total = 0;
	logic [31:0] stim_state;
	logic [31:0] ready_state;

	c64_loader_top #(
		.WQ_DEPTH (WQ_DEPTH)
	) dut_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_valid_i      (dl_valid_i),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_active_i     (dl_active_i),
		.dl_ready_o      (dl_ready_o),
		.mem_ready_i     (mem_ready_i),
		.mem_valid_o     (mem_valid_o),
		.mem_addr_o      (mem_addr_o),
		.mem_data_o      (mem_data_o),
		.busy_o          (busy_o),
		.bank_valid_o    (bank_valid_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_raddr_o    (bank_raddr_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o)
	);

	bind mem_write_queue tb_c64_loader_assert queue_assert_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.prg_push_i  (prg_push_i),
		.crt_push_i  (crt_push_i),
		.room_o      (room_o),
		.mem_valid_o (mem_valid_o),
		.mem_ready_i (mem_ready_i),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

	//========================================
	// Random numbers and model helpers
	//========================================
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		stim_state = lcg_step(stim_state);
		return stim_state[31:8] % n;
	endfunction

	// Next 8 KB boundary at or above the address
	function automatic mem_addr_t align_8k(input mem_addr_t a);
		return (a + 25'h1FFF) & ~25'h1FFF;
	endfunction

	function automatic int mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("** Error %s: got %0h expected %0h", name, got, want);
			return 1;
		end
		return 0;
	endfunction

	task automatic expect_write(input mem_addr_t a, input byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	//========================================
	// Compare tasks
	//========================================
	task automatic check_write(input mem_addr_t got_addr, input byte_t got_data,
			input mem_addr_t want_addr, input byte_t want_data);
		write_errs += mismatch("mem_addr_o", got_addr, want_addr);
		write_errs += mismatch("mem_data_o", got_data, want_data);
	endtask

	task automatic check_bank(input byte_t got_type, input crt_word_t got_num,
			input c64_addr_t got_laddr, input crt_word_t got_size, input mem_addr_t got_raddr);
		bank_errs += mismatch("bank_type_o", got_type, exp_type.pop_front());
		bank_errs += mismatch("bank_num_o", got_num, exp_num.pop_front());
		bank_errs += mismatch("bank_laddr_o", got_laddr, exp_laddr.pop_front());
		bank_errs += mismatch("bank_size_o", got_size, exp_size.pop_front());
		bank_errs += mismatch("bank_raddr_o", got_raddr, exp_raddr.pop_front());
	endtask

	task automatic check_cart(input crt_word_t got_id, input byte_t got_exrom,
			input byte_t got_game);
		cart_errs += mismatch("cart_id_o", got_id, exp_id.pop_front());
		cart_errs += mismatch("cart_exrom_o", got_exrom, exp_exrom.pop_front());
		cart_errs += mismatch("cart_game_o", got_game, exp_game.pop_front());
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		flag_errs += mismatch(name, got, want);
	endtask

	//========================================
	// File builders with the reference model
	//========================================
	task automatic build_prg();
		c64_addr_t load;
		c64_addr_t run;
		int        n;
		int        i;
		byte_t     d;
		load = c64_addr_t'(rand_below(65536));
		n    = 1 + rand_below(40);
		file_idx.push_back(dl_index_t'(IDX_PRG));
		file_len.push_back(n + 2);
		stim_q.push_back(load[7:0]);
		stim_q.push_back(load[15:8]);
		run = load;
		for (i = 0; i < n; i++) begin
			d = byte_t'(rand_below(256));
			stim_q.push_back(d);
			expect_write(mem_addr_t'(run), d);
			run = run + 1'b1;
		end
		// BASIC pointers, ascending page-zero addresses
		expect_write(25'h2B, load[7:0]);
		expect_write(25'h2C, load[15:8]);
		for (i = 0; i < 3; i++) begin
			expect_write(mem_addr_t'(8'h2D + 2 * i), run[7:0]);
			expect_write(mem_addr_t'(8'h2E + 2 * i), run[15:8]);
		end
		expect_write(25'hAC, load[7:0]);
		expect_write(25'hAD, load[15:8]);
		expect_write(25'hAE, run[7:0]);
		expect_write(25'hAF, run[15:8]);
	endtask

	task automatic build_crt();
		crt_word_t id;
		byte_t     exrom;
		byte_t     game;
		byte_t     hdr [16];
		byte_t     d;
		mem_addr_t raddr;
		int        start;
		int        npk;
		int        len;
		int        p;
		int        i;
		id    = crt_word_t'(rand_below(65536));
		exrom = byte_t'(rand_below(256));
		game  = byte_t'(rand_below(256));
		start = stim_q.size();
		file_idx.push_back(dl_index_t'(rand_below(2) ? IDX_CRT : IDX_CRT_ALT));
		for (i = 0; i < CRT_DATA_START; i++) begin
			case (i)
				'h16:    d = id[15:8];
				'h17:    d = id[7:0];
				'h18:    d = exrom;
				'h19:    d = game;
				default: d = byte_t'(rand_below(256));
			endcase
			stim_q.push_back(d);
		end
		npk   = 2 + rand_below(2);
		raddr = CRT_BASE;
		for (p = 0; p < npk; p++) begin
			len   = 1 + rand_below(20);
			raddr = align_8k(raddr);
			for (i = 0; i < 16; i++)
				hdr[i] = byte_t'(rand_below(256));
			{hdr[0], hdr[1], hdr[2], hdr[3]} = "CHIP";
			// Packet length counts its own header
			{hdr[4], hdr[5], hdr[6], hdr[7]} = crt_len_t'(len + CHIP_HDR_LEN);
			exp_type.push_back(hdr[9]);
			exp_num.push_back({hdr[10], hdr[11]});
			exp_laddr.push_back({hdr[12], hdr[13]});
			exp_size.push_back({hdr[14], hdr[15]});
			exp_raddr.push_back(raddr);
			bank_end.push_back(stim_q.size() + 15);
			for (i = 0; i < 16; i++)
				stim_q.push_back(hdr[i]);
			for (i = 0; i < len; i++) begin
				d = byte_t'(rand_below(256));
				stim_q.push_back(d);
				expect_write(mem_addr_t'(raddr + i), d);
			end
			raddr = raddr + len;
		end
		file_len.push_back(stim_q.size() - start);
		exp_id.push_back(id);
		exp_exrom.push_back(exrom);
		exp_game.push_back(game);
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic send_byte(input mem_addr_t off, input byte_t d);
		dl_valid_i = 1'b0;
		if (rand_below(4) == 0)
			repeat (1 + rand_below(2)) @(negedge clk_sys);
		dl_valid_i = 1'b1;
		dl_addr_i  = off;
		dl_data_i  = d;
		// Ready comes from registers and holds until the next rising edge
		while (!dl_ready_o)
			@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	//========================================
	// Clock, memory stalls and monitors
	//========================================
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Memory stalls on about a third of the cycles
	initial begin
		wait (reset_n === 1'b1);
		forever begin
			@(negedge clk_sys);
			ready_state = lcg_step(ready_state);
			mem_ready_i = (ready_state[31:8] % 3) != 0;
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && mem_valid_o && mem_ready_i) begin
			if (exp_addr.size() == 0) begin
				$display("Unexpected memory write to %h after the expected sequence", mem_addr_o);
				write_errs++;
			end else begin
				check_write(mem_addr_o, mem_data_o, exp_addr.pop_front(), exp_data.pop_front());
			end
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && bank_valid_o) begin
			if (exp_type.size() == 0) begin
				$display("Unexpected bank record for bank %h", bank_num_o);
				bank_errs++;
			end else begin
				check_bank(bank_type_o, bank_num_o, bank_laddr_o, bank_size_o, bank_raddr_o);
			end
		end
	end

	initial begin
		wait (stim_total > 0);
		repeat (20 * stim_total) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", 20 * stim_total);
		$display("=== FAIL ===");
		$finish;
	end

	//========================================
	// Main sequence
	//========================================
	initial begin
		int   f;
		int   k;
		int   pos;
		logic crt_seen;
		reset_n     = 1'b0;
		dl_valid_i  = 1'b0;
		dl_index_i  = '0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		dl_active_i = 1'b0;
		mem_ready_i = 1'b1;
		crt_seen    = 1'b0;
		stim_state  = 32'd90;
		for (f = 0; f < ROUNDS; f++) begin
			build_prg();
			build_crt();
		end
		ready_state = ~stim_state;
		stim_total  = stim_q.size();

		repeat (5) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_flag("mem_valid_o", mem_valid_o, 1'b0);
		check_flag("bank_valid_o", bank_valid_o, 1'b0);
		check_flag("cart_attached_o", cart_attached_o, 1'b0);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("dl_ready_o", dl_ready_o, 1'b1);

		pos = 0;
		for (f = 0; f < file_idx.size(); f++) begin
			dl_index_i  = file_idx[f];
			dl_active_i = 1'b1;
			for (k = 0; k < file_len[f]; k++) begin
				send_byte(mem_addr_t'(k), stim_q[pos + k]);
				// Bank record one cycle after its last header byte
				if (bank_end.size() != 0 && bank_end[0] == pos + k) begin
					check_flag("bank_valid_o", bank_valid_o, 1'b1);
					bank_end.delete(0);
				end
			end
			check_flag("cart_attached_o", cart_attached_o, crt_seen);
			pos         = pos + file_len[f];
			dl_valid_i  = 1'b0;
			dl_active_i = 1'b0;
			@(negedge clk_sys);
			if (file_idx[f] == IDX_PRG) begin
				// Patch runs from the cycle after the end of the download
				check_flag("busy_o", busy_o, 1'b1);
				while (busy_o)
					@(negedge clk_sys);
				check_flag("cart_attached_o", cart_attached_o, crt_seen);
			end else begin
				crt_seen = 1'b1;
				check_flag("cart_attached_o", cart_attached_o, 1'b1);
				check_cart(cart_id_o, cart_exrom_o, cart_game_o);
			end
		end

		while (exp_addr.size() != 0)
			@(negedge clk_sys);
		repeat (8) @(negedge clk_sys);
		if (exp_type.size() != 0) begin
			$display("Missing %0d bank records at the end of the run", exp_type.size());
			bank_errs++;
		end
		$display("Errors: write %0d, bank %0d, cart %0d, flag %0d",
			write_errs, bank_errs, cart_errs, flag_errs);
		if (write_errs + bank_errs + cart_errs + flag_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_c64_loader_assert.sv ====
//========================================
// Bound checks on the write queue
// Memory port held under back-pressure
// Push rules and reset state
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_c64_loader_assert
	import loader_pkg::*;
(
	input wire            clk_sys,
	input wire            reset_n,
	input wire            prg_push_i,
	input wire            crt_push_i,
	input wire            room_o,
	input wire            mem_valid_o,
	input wire            mem_ready_i,
	input wire mem_addr_t mem_addr_o,
	input wire byte_t     mem_data_o
);

	// Write held until the memory takes it
	a_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_valid_o && !mem_ready_i |=>
			mem_valid_o && $stable(mem_addr_o) && $stable(mem_data_o))
		else $error("memory write changed while the memory stalled");

	// Each parser decodes its own file type
	a_one_push: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(prg_push_i && crt_push_i))
		else $error("both parsers pushed in the same cycle");

	a_room: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!room_o |-> !(prg_push_i || crt_push_i))
		else $error("push arrived while the queue was full");

	a_reset: assert property (@(posedge clk_sys)
		!reset_n |=> !mem_valid_o)
		else $error("memory valid high during reset");

endmodule

`default_nettype wire

// ==== design/c64_loader_top.sv ====
//========================================
// Loader top level
// PRG injector and CRT parser feeding the
// shared memory write queue
//========================================
`timescale 1ns/1ps
`default_nettype none

module c64_loader_top
	import loader_pkg::*;
#(
	parameter int WQ_DEPTH = 4
) (
	input  wire            clk_sys,
	input  wire            reset_n,
	// Download port
	input  wire            dl_valid_i,
	input  wire dl_index_t dl_index_i,
	input  wire mem_addr_t dl_addr_i,
	input  wire byte_t     dl_data_i,
	input  wire            dl_active_i,
	output wire            dl_ready_o,
	// Memory write port
	input  wire            mem_ready_i,
	output wire            mem_valid_o,
	output wire mem_addr_t mem_addr_o,
	output wire byte_t     mem_data_o,
	output wire            busy_o,
	// Cartridge records
	output wire            bank_valid_o,
	output wire byte_t     bank_type_o,
	output wire crt_word_t bank_num_o,
	output wire c64_addr_t bank_laddr_o,
	output wire crt_word_t bank_size_o,
	output wire mem_addr_t bank_raddr_o,
	output wire crt_word_t cart_id_o,
	output wire byte_t     cart_exrom_o,
	output wire byte_t     cart_game_o,
	output wire            cart_attached_o
);

	logic      wq_room;
	logic      prg_push;
	mem_addr_t prg_addr;
	byte_t     prg_data;
	logic      crt_push;
	mem_addr_t crt_addr;
	byte_t     crt_data;

	// Host waits while the queue is full or the pointer patch runs
	assign dl_ready_o = wq_room & ~busy_o;

	prg_injector prg_injector_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_valid_i  (dl_valid_i),
		.dl_ready_i  (dl_ready_o),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_active_i (dl_active_i),
		.wq_room_i   (wq_room),
		.push_o      (prg_push),
		.push_addr_o (prg_addr),
		.push_data_o (prg_data),
		.busy_o      (busy_o)
	);

	crt_parser crt_parser_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_valid_i      (dl_valid_i),
		.dl_ready_i      (dl_ready_o),
		.dl_index_i      (dl_index_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.dl_active_i     (dl_active_i),
		.push_o          (crt_push),
		.push_addr_o     (crt_addr),
		.push_data_o     (crt_data),
		.bank_valid_o    (bank_valid_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_raddr_o    (bank_raddr_o),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o)
	);

	mem_write_queue #(
		.WQ_DEPTH (WQ_DEPTH)
	) mem_write_queue_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.prg_push_i  (prg_push),
		.prg_addr_i  (prg_addr),
		.prg_data_i  (prg_data),
		.crt_push_i  (crt_push),
		.crt_addr_i  (crt_addr),
		.crt_data_i  (crt_data),
		.mem_ready_i (mem_ready_i),
		.room_o      (wq_room),
		.mem_valid_o (mem_valid_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

`default_nettype wire

// ==== design/mem_write_queue.sv ====
//========================================
// Memory write queue
// FIFO of byte writes from both parsers
// Registered valid/ready memory port
//========================================
`timescale 1ns/1ps
`default_nettype none

module mem_write_queue
	import loader_pkg::*;
#(
	parameter int WQ_DEPTH = 4
) (
	input  wire            clk_sys,
	input  wire            reset_n,
	input  wire            prg_push_i,
	input  wire mem_addr_t prg_addr_i,
	input  wire byte_t     prg_data_i,
	input  wire            crt_push_i,
	input  wire mem_addr_t crt_addr_i,
	input  wire byte_t     crt_data_i,
	input  wire            mem_ready_i,
	output logic           room_o,
	output logic           mem_valid_o,
	output mem_addr_t      mem_addr_o,
	output byte_t          mem_data_o
);

	localparam int AW = $clog2(WQ_DEPTH);

	mem_addr_t     addr_q [WQ_DEPTH];
	byte_t         data_q [WQ_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          push;
	mem_addr_t     push_addr;
	byte_t         push_data;
	logic          out_free;
	logic          pop;
	logic          bypass;
	logic          store;

	assign push      = prg_push_i | crt_push_i;
	assign push_addr = prg_push_i ? prg_addr_i : crt_addr_i;
	assign push_data = prg_push_i ? prg_data_i : crt_data_i;

	// Output stage can load when empty or completing this cycle
	assign out_free = !mem_valid_o || mem_ready_i;
	assign pop      = out_free && (count != '0);
	// Straight to the output when nothing older is waiting
	assign bypass   = push && out_free && (count == '0);
	assign store    = push && !bypass;
	assign room_o   = (count != WQ_DEPTH);

	always_ff @(posedge clk_sys) begin
		if (store) begin
			addr_q[wr_ptr] <= push_addr;
			data_q[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pop) begin
			mem_addr_o <= addr_q[rd_ptr];
			mem_data_o <= data_q[rd_ptr];
		end else if (bypass) begin
			mem_addr_o <= push_addr;
			mem_data_o <= push_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			mem_valid_o <= 1'b0;
		end else begin
			if (store)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (store && !pop)
				count <= count + 1'b1;
			else if (pop && !store)
				count <= count - 1'b1;
			if (out_free)
				mem_valid_o <= pop | bypass;
		end
	end

endmodule

`default_nettype wire

// ==== design/crt_parser.sv ====
//========================================
// CRT parser
// File header capture (id, EXROM, GAME)
// CHIP packet walk with 8 KB alignment
// Bank records and the attached flag
//========================================
`timescale 1ns/1ps
`default_nettype none

module crt_parser
	import loader_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset_n,
	input  wire            dl_valid_i,
	input  wire            dl_ready_i,
	input  wire dl_index_t dl_index_i,
	input  wire mem_addr_t dl_addr_i,
	input  wire byte_t     dl_data_i,
	input  wire            dl_active_i,
	output logic           push_o,
	output mem_addr_t      push_addr_o,
	output byte_t          push_data_o,
	output logic           bank_valid_o,
	output byte_t          bank_type_o,
	output crt_word_t      bank_num_o,
	output c64_addr_t      bank_laddr_o,
	output crt_word_t      bank_size_o,
	output mem_addr_t      bank_raddr_o,
	output crt_word_t      cart_id_o,
	output byte_t          cart_exrom_o,
	output byte_t          cart_game_o,
	output logic           cart_attached_o
);

	crt_state_e state;
	logic [3:0] hdr_cnt;
	crt_len_t   chip_len;
	mem_addr_t  wr_addr;
	logic       is_crt;
	logic       take;
	logic       dl_active_q;
	logic       last_crt;

	assign is_crt = (dl_index_i == IDX_CRT) || (dl_index_i == IDX_CRT_ALT);
	assign take   = dl_valid_i & dl_ready_i & is_crt;

	assign push_o      = take && (state == CRT_CHIP_DATA) && (dl_addr_i >= CRT_DATA_START);
	assign push_addr_o = wr_addr;
	assign push_data_o = dl_data_i;

	//========================================
	// Walk control and attach flag
	//========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= CRT_FILE_HDR;
			hdr_cnt         <= '0;
			dl_active_q     <= 1'b0;
			last_crt        <= 1'b0;
			bank_valid_o    <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			dl_active_q  <= dl_active_i;
			bank_valid_o <= 1'b0;
			if (dl_active_i)
				last_crt <= is_crt;
			// End of a CRT download
			if (dl_active_q && !dl_active_i && last_crt) begin
				cart_attached_o <= 1'b1;
				state           <= CRT_FILE_HDR;
			end
			if (take) begin
				case (state)
					CRT_FILE_HDR: begin
						if (dl_addr_i == CRT_DATA_START - 1) begin
							state   <= CRT_CHIP_HDR;
							hdr_cnt <= '0;
						end
					end
					CRT_CHIP_HDR: begin
						// Counter wraps to zero for the next packet
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == 4'd15) begin
							bank_valid_o <= 1'b1;
							if (chip_len != '0)
								state <= CRT_CHIP_DATA;
						end
					end
					CRT_CHIP_DATA: begin
						if (chip_len == 32'd1)
							state <= CRT_CHIP_HDR;
					end
					default: state <= CRT_FILE_HDR;
				endcase
				// A new file always starts in the file header
				if (dl_addr_i == 25'd0)
					state <= CRT_FILE_HDR;
			end
		end
	end

	//========================================
	// Header fields and write address
	//========================================
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (dl_addr_i == 25'd0)
				wr_addr <= CRT_BASE;
			if (state == CRT_FILE_HDR) begin
				case (dl_addr_i)
					25'h16:  cart_id_o[15:8] <= dl_data_i;
					25'h17:  cart_id_o[7:0]  <= dl_data_i;
					25'h18:  cart_exrom_o    <= dl_data_i;
					25'h19:  cart_game_o     <= dl_data_i;
					default: ;
				endcase
			end
			if (state == CRT_CHIP_HDR) begin
				case (hdr_cnt)
					4'd0: begin
						// Round up to the next 8 KB boundary
						if (wr_addr[12:0] != 13'd0)
							wr_addr <= {wr_addr[24:13] + 1'b1, 13'd0};
					end
					4'd4:  chip_len[31:24]    <= dl_data_i;
					4'd5:  chip_len[23:16]    <= dl_data_i;
					4'd6:  chip_len[15:8]     <= dl_data_i;
					4'd7:  chip_len[7:0]      <= dl_data_i;
					// Packet length includes its own header
					4'd8:  chip_len           <= chip_len - CHIP_HDR_LEN;
					4'd9:  bank_type_o        <= dl_data_i;
					4'd10: bank_num_o[15:8]   <= dl_data_i;
					4'd11: bank_num_o[7:0]    <= dl_data_i;
					4'd12: bank_laddr_o[15:8] <= dl_data_i;
					4'd13: bank_laddr_o[7:0]  <= dl_data_i;
					4'd14: bank_size_o[15:8]  <= dl_data_i;
					4'd15: begin
						bank_size_o[7:0] <= dl_data_i;
						bank_raddr_o     <= wr_addr;
					end
					default: ;
				endcase
			end
			if (state == CRT_CHIP_DATA) begin
				wr_addr  <= wr_addr + 1'b1;
				chip_len <= chip_len - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/prg_injector.sv ====
//========================================
// PRG injector
// Load address capture and data writes
// Page-zero BASIC pointer patch at the end
// of a PRG download
//========================================
`timescale 1ns/1ps
`default_nettype none

module prg_injector
	import loader_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset_n,
	input  wire            dl_valid_i,
	input  wire            dl_ready_i,
	input  wire dl_index_t dl_index_i,
	input  wire mem_addr_t dl_addr_i,
	input  wire byte_t     dl_data_i,
	input  wire            dl_active_i,
	input  wire            wq_room_i,
	output logic           push_o,
	output mem_addr_t      push_addr_o,
	output byte_t          push_data_o,
	output logic           busy_o
);

	logic       is_prg;
	logic       take;
	logic       dl_active_q;
	logic       last_prg;
	logic       patch_go;
	logic [3:0] step;
	c64_addr_t  start_addr;
	c64_addr_t  end_addr;
	c64_addr_t  patch_src;
	byte_t      patch_addr;
	byte_t      patch_data;

	assign is_prg = (dl_index_i == IDX_PRG);
	assign take   = dl_valid_i & dl_ready_i & is_prg;

	// First cycle with the active flag low after a PRG file
	assign patch_go = dl_active_q & ~dl_active_i & last_prg;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_active_q <= 1'b0;
			last_prg    <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_active_i)
				last_prg <= is_prg;
		end
	end

	//========================================
	// Load address and running end address
	//========================================
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (dl_addr_i == 25'd0) begin
				start_addr[7:0] <= dl_data_i;
				end_addr[7:0]   <= dl_data_i;
			end else if (dl_addr_i == 25'd1) begin
				start_addr[15:8] <= dl_data_i;
				end_addr[15:8]   <= dl_data_i;
			end else begin
				// Data byte goes out at end_addr, which then moves on
				end_addr <= end_addr + 1'b1;
			end
		end
	end

	//========================================
	// Pointer patch sequence
	//========================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy_o <= 1'b0;
			step   <= '0;
		end else if (patch_go) begin
			busy_o <= 1'b1;
			step   <= '0;
		end else if (busy_o && wq_room_i) begin
			step <= step + 1'b1;
			if (step == 4'd11)
				busy_o <= 1'b0;
		end
	end

	// TXT, VAR, ARY, STR, then SAVE_START and LOAD_END
	always_comb begin
		case (step)
			4'd0:    patch_addr = 8'h2B;
			4'd1:    patch_addr = 8'h2C;
			4'd2:    patch_addr = 8'h2D;
			4'd3:    patch_addr = 8'h2E;
			4'd4:    patch_addr = 8'h2F;
			4'd5:    patch_addr = 8'h30;
			4'd6:    patch_addr = 8'h31;
			4'd7:    patch_addr = 8'h32;
			4'd8:    patch_addr = 8'hAC;
			4'd9:    patch_addr = 8'hAD;
			4'd10:   patch_addr = 8'hAE;
			default: patch_addr = 8'hAF;
		endcase
	end

	// Steps 0, 1, 8 and 9 carry the start address, the rest the end
	assign patch_src  = (step[3:1] == 3'd0 || step[3:1] == 3'd4) ? start_addr : end_addr;
	// Even steps take the low byte
	assign patch_data = step[0] ? patch_src[15:8] : patch_src[7:0];

	assign push_o      = busy_o ? wq_room_i : (take && dl_addr_i > 25'd1);
	assign push_addr_o = busy_o ? mem_addr_t'(patch_addr) : mem_addr_t'(end_addr);
	assign push_data_o = busy_o ? patch_data : dl_data_i;

endmodule

`default_nettype wire

// ==== design/loader_pkg.sv ====
//========================================
// Loader package
// Shared widths and types of the download path
// File-type indices and cartridge constants
// CRT walk state encoding
//========================================
`default_nettype none

package loader_pkg;

	// Shared memory byte address
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  byte_t;
	// Address in the computer's own 64 KB map
	typedef logic [15:0] c64_addr_t;
	typedef logic [7:0]  dl_index_t;
	// Big-endian fields of a CRT image
	typedef logic [15:0] crt_word_t;
	typedef logic [31:0] crt_len_t;

	//========================================
	// File-type indices from the host
	//========================================
	localparam int IDX_PRG     = 'h04;
	localparam int IDX_CRT     = 'h05;
	localparam int IDX_CRT_ALT = 'hC0;

	//========================================
	// Cartridge image layout
	//========================================
	// Banks are placed upward from here
	localparam mem_addr_t CRT_BASE = 25'h100000;
	// First CHIP packet follows the file header
	localparam int CRT_DATA_START = 'h40;
	localparam int CHIP_HDR_LEN   = 16;

	// CRT walk states
	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_CHIP_HDR,
		CRT_CHIP_DATA
	} crt_state_e;

endpackage

`default_nettype wire
